/* common/miniMips_settings.svh */
`ifndef MINIMIPS_SETTINGS_SVH
`define MINIMIPS_SETTINGS_SVH

`define RESET_PC    32'h0000_3000

// Opcodes
`define OP_SPECIAL  6'h00
`define OP_J        6'h02
`define OP_BEQ      6'h04
`define OP_BNE      6'h05
`define OP_ADDIU    6'h09
`define OP_ORI      6'h0d
`define OP_LUI      6'h0f
`define OP_LW       6'h23
`define OP_SW       6'h2b

// R-type funct field
`define FN_SLL      6'h00
`define FN_ADDU     6'h21
`define FN_SUBU     6'h23
`define FN_AND      6'h24
`define FN_OR       6'h25
`define FN_SLT      6'h2a

// ALU operations
`define ALU_ADD     4'd0
`define ALU_SUB     4'd1
`define ALU_AND     4'd2
`define ALU_OR      4'd3
`define ALU_SLT     4'd4
`define ALU_SLL     4'd5
`define ALU_LUI     4'd6

`endif

/* common/cpuPkg.sv */
package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [3:0]  aluOp_t;

    // Decode to execute
    typedef struct packed {
        logic        valid;
        word_t       pc;
        regAddr_t    rsAddr;
        regAddr_t    rtAddr;
        word_t       rsData;
        word_t       rtData;
        word_t       imm;
        logic [4:0]  shamt;
        aluOp_t      aluOp;
        logic        useImm;
        logic        isLoad;
        logic        isStore;
        logic        isBeq;
        logic        isBne;
        logic        isJump;
        logic [25:0] jumpTarget;
        logic        regWEn;
        regAddr_t    regWAddr;
    } decodedInstr_t;

    // Execute to result
    typedef struct packed {
        logic     valid;
        word_t    aluOut;
        word_t    storeData;
        logic     isLoad;
        logic     isStore;
        logic     regWEn;
        regAddr_t regWAddr;
    } execResult_t;

    // Register write and forwarding source
    typedef struct packed {
        logic     en;
        regAddr_t addr;
        word_t    data;
    } regWrite_t;

endpackage

/* decode/regFile.sv */
module regFile (
    input  wire               clk,
    input  wire               rstN,
    input  cpuPkg::regAddr_t  rsAddr,
    input  cpuPkg::regAddr_t  rtAddr,
    input  cpuPkg::regWrite_t write,
    output cpuPkg::word_t     rsData,
    output cpuPkg::word_t     rtData
);
    cpuPkg::word_t regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write.en && write.addr != '0) begin
            regs[write.addr] <= write.data;
        end
    end

    // Write-through so decode sees a retiring result
    assign rsData = (rsAddr == '0) ? '0 :
                    (write.en && write.addr == rsAddr) ? write.data : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 :
                    (write.en && write.addr == rtAddr) ? write.data : regs[rtAddr];

    // Register 0 is never a write target
    assert property (@(posedge clk) disable iff (!rstN) write.en |-> (write.addr != '0));

endmodule

/* decode/decodeStage.sv */
`include "miniMips_settings.svh"

module decodeStage (
    input  wire                   clk,
    input  wire                   rstN,
    input  cpuPkg::word_t         IData,
    input  wire                   IReady,
    input  wire                   memStall,
    input  wire                   redirect,
    input  cpuPkg::word_t         redirectPc,
    input  cpuPkg::word_t         rsData,
    input  cpuPkg::word_t         rtData,
    output cpuPkg::word_t         IAddr,
    output cpuPkg::regAddr_t      rsAddr,
    output cpuPkg::regAddr_t      rtAddr,
    output cpuPkg::decodedInstr_t decoded
);
    cpuPkg::word_t         pc;
    cpuPkg::word_t         instrWord;
    cpuPkg::word_t         instrPc;
    logic                  instrValid;
    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [15:0]           immField;
    cpuPkg::decodedInstr_t decodeNext;

    assign IAddr = pc;
    assign opcode = instrWord[31:26];
    assign funct = instrWord[5:0];
    assign immField = instrWord[15:0];
    assign rsAddr = instrWord[25:21];
    assign rtAddr = instrWord[20:16];

    // A missing IReady leaves a bubble
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `RESET_PC;
            instrValid <= 1'b0;
        end else if (!memStall) begin
            if (redirect) begin
                pc <= redirectPc;
                instrValid <= 1'b0;
            end else begin
                instrValid <= IReady;
                if (IReady) begin
                    pc <= pc + 32'd4;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!memStall && !redirect && IReady) begin
            instrWord <= IData;
            instrPc <= pc;
        end
    end

    always_comb begin
        decodeNext = '0;
        decodeNext.valid = instrValid;
        decodeNext.pc = instrPc;
        decodeNext.rsAddr = rsAddr;
        decodeNext.rtAddr = rtAddr;
        decodeNext.rsData = rsData;
        decodeNext.rtData = rtData;
        decodeNext.imm = {{16{immField[15]}}, immField};
        decodeNext.shamt = instrWord[10:6];
        decodeNext.jumpTarget = instrWord[25:0];
        decodeNext.regWAddr = rtAddr;
        case (opcode)
            `OP_SPECIAL: begin
                decodeNext.regWAddr = instrWord[15:11];
                decodeNext.regWEn = 1'b1;
                case (funct)
                    `FN_ADDU: decodeNext.aluOp = `ALU_ADD;
                    `FN_SUBU: decodeNext.aluOp = `ALU_SUB;
                    `FN_AND:  decodeNext.aluOp = `ALU_AND;
                    `FN_OR:   decodeNext.aluOp = `ALU_OR;
                    `FN_SLT:  decodeNext.aluOp = `ALU_SLT;
                    `FN_SLL:  decodeNext.aluOp = `ALU_SLL;
                    default:  decodeNext.regWEn = 1'b0;
                endcase
            end
            `OP_ADDIU: begin
                decodeNext.aluOp = `ALU_ADD;
                decodeNext.useImm = 1'b1;
                decodeNext.regWEn = 1'b1;
            end
            `OP_ORI: begin
                decodeNext.aluOp = `ALU_OR;
                decodeNext.imm = {16'h0000, immField};
                decodeNext.useImm = 1'b1;
                decodeNext.regWEn = 1'b1;
            end
            `OP_LUI: begin
                decodeNext.aluOp = `ALU_LUI;
                decodeNext.imm = {16'h0000, immField};
                decodeNext.useImm = 1'b1;
                decodeNext.regWEn = 1'b1;
            end
            `OP_LW: begin
                decodeNext.aluOp = `ALU_ADD;
                decodeNext.useImm = 1'b1;
                decodeNext.isLoad = 1'b1;
                decodeNext.regWEn = 1'b1;
            end
            `OP_SW: begin
                decodeNext.aluOp = `ALU_ADD;
                decodeNext.useImm = 1'b1;
                decodeNext.isStore = 1'b1;
            end
            `OP_BEQ: decodeNext.isBeq = 1'b1;
            `OP_BNE: decodeNext.isBne = 1'b1;
            `OP_J:   decodeNext.isJump = 1'b1;
            // Unknown opcodes run as a nop
            default: decodeNext.regWEn = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            decoded <= '0;
        end else if (!memStall) begin
            if (redirect) begin
                decoded <= '0;
            end else begin
                decoded <= decodeNext;
            end
        end
    end

    // Both younger slots are squashed after a redirect
    assert property (@(posedge clk) disable iff (!rstN)
        ($past(redirect && !memStall) || $past(redirect && !memStall, 2))
        |-> !decoded.valid);

endmodule

/* hdl/executeStage.sv */
`include "miniMips_settings.svh"

module executeStage (
    input  wire                   clk,
    input  wire                   rstN,
    input  cpuPkg::decodedInstr_t decoded,
    input  cpuPkg::regWrite_t     forward,
    input  wire                   memStall,
    output logic                  redirect,
    output cpuPkg::word_t         redirectPc,
    output cpuPkg::execResult_t   result
);
    cpuPkg::word_t       opA;
    cpuPkg::word_t       rtVal;
    cpuPkg::word_t       opB;
    cpuPkg::word_t       aluOut;
    cpuPkg::word_t       seqPc;
    cpuPkg::word_t       branchPc;
    logic                operandsEqual;
    cpuPkg::execResult_t resultNext;

    // Result stage forwarding
    assign opA = (forward.en && forward.addr == decoded.rsAddr) ? forward.data : decoded.rsData;
    assign rtVal = (forward.en && forward.addr == decoded.rtAddr) ? forward.data : decoded.rtData;
    assign opB = decoded.useImm ? decoded.imm : rtVal;

    always_comb begin
        case (decoded.aluOp)
            `ALU_ADD: aluOut = opA + opB;
            `ALU_SUB: aluOut = opA - opB;
            `ALU_AND: aluOut = opA & opB;
            `ALU_OR:  aluOut = opA | opB;
            `ALU_SLT: aluOut = {31'b0, $signed(opA) < $signed(opB)};
            `ALU_SLL: aluOut = opB << decoded.shamt;
            `ALU_LUI: aluOut = {opB[15:0], 16'h0000};
            default:  aluOut = opA + opB;
        endcase
    end

    // Branch resolution without delay slot
    assign seqPc = decoded.pc + 32'd4;
    assign branchPc = seqPc + {decoded.imm[29:0], 2'b00};
    assign operandsEqual = (opA == rtVal);
    assign redirect = decoded.valid && (decoded.isJump ||
                      (decoded.isBeq && operandsEqual) ||
                      (decoded.isBne && !operandsEqual));
    assign redirectPc = decoded.isJump ? {seqPc[31:28], decoded.jumpTarget, 2'b00} : branchPc;

    always_comb begin
        resultNext.valid = decoded.valid;
        resultNext.aluOut = aluOut;
        resultNext.storeData = rtVal;
        resultNext.isLoad = decoded.isLoad;
        resultNext.isStore = decoded.isStore;
        resultNext.regWEn = decoded.regWEn;
        resultNext.regWAddr = decoded.regWAddr;
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
        end else if (!memStall) begin
            result <= resultNext;
        end
    end

    // A branch or jump neither writes a register nor stores
    assert property (@(posedge clk) disable iff (!rstN)
        redirect |-> (!decoded.regWEn && !decoded.isStore));

endmodule

/* hdl/resultStage.sv */
module resultStage (
    input  cpuPkg::execResult_t result,
    input  cpuPkg::word_t       DRData,
    input  wire                 DReady,
    output cpuPkg::word_t       DAddr,
    output cpuPkg::word_t       DWData,
    output logic                DREn,
    output logic                DWEn,
    output logic                memStall,
    output cpuPkg::regWrite_t   write
);
    logic memAccess;
    logic retire;

    assign DREn = result.valid && result.isLoad;
    assign DWEn = result.valid && result.isStore;
    assign DAddr = result.aluOut;
    assign DWData = result.storeData;

    // Hold the whole pipe until the data port answers
    assign memAccess = DREn || DWEn;
    assign memStall = memAccess && !DReady;
    assign retire = result.valid && !memStall;

    always_comb begin
        write.en = retire && result.regWEn && (result.regWAddr != '0);
        write.addr = result.regWAddr;
        write.data = result.isLoad ? DRData : result.aluOut;
    end

    // Load and store flags come from disjoint opcodes in decode
    always_comb begin
        assert (!(DREn && DWEn)) else $error("data read and write requested together");
    end

endmodule

/* hdl/cpuCore.sv */
module cpuCore (
    input  wire           clk,
    input  wire           rstN,
    output cpuPkg::word_t IAddr,
    input  cpuPkg::word_t IData,
    input  wire           IReady,
    output cpuPkg::word_t DAddr,
    output logic          DREn,
    output logic          DWEn,
    output cpuPkg::word_t DWData,
    input  cpuPkg::word_t DRData,
    input  wire           DReady
);
    cpuPkg::decodedInstr_t decoded;
    cpuPkg::execResult_t   result;
    cpuPkg::regWrite_t     write;
    cpuPkg::regAddr_t      rsAddr;
    cpuPkg::regAddr_t      rtAddr;
    cpuPkg::word_t         rsData;
    cpuPkg::word_t         rtData;
    cpuPkg::word_t         redirectPc;
    logic                  redirect;
    logic                  memStall;

    decodeStage d (
        .clk(clk), .rstN(rstN),
        .IData(IData), .IReady(IReady), .IAddr(IAddr),
        .memStall(memStall), .redirect(redirect), .redirectPc(redirectPc),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .rsData(rsData), .rtData(rtData),
        .decoded(decoded)
    );

    regFile grf (
        .clk(clk), .rstN(rstN),
        .rsAddr(rsAddr), .rtAddr(rtAddr), .write(write),
        .rsData(rsData), .rtData(rtData)
    );

    executeStage e (
        .clk(clk), .rstN(rstN),
        .decoded(decoded), .forward(write), .memStall(memStall),
        .redirect(redirect), .redirectPc(redirectPc), .result(result)
    );

    resultStage r (
        .result(result), .DRData(DRData), .DReady(DReady),
        .DAddr(DAddr), .DWData(DWData), .DREn(DREn), .DWEn(DWEn),
        .memStall(memStall), .write(write)
    );

endmodule

/* tests/tbPrograms.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Programs are copied to `RESET_PC one at a time and end in a self-loop J
localparam int NUM_PROGS = 4;
localparam int PROG_WORDS = 44;
localparam int progStart [NUM_PROGS] = '{0, 16, 23, 39};
localparam int progLen [NUM_PROGS] = '{16, 7, 16, 5};

localparam cpuPkg::word_t progWords [PROG_WORDS] = '{
    // Dependent ALU chain at 0
    {`OP_ADDIU, 5'd0, 5'd1, 16'd5},
    {`OP_LUI, 5'd0, 5'd2, 16'h1234},
    {`OP_ORI, 5'd2, 5'd2, 16'h5678},
    {`OP_SPECIAL, 5'd1, 5'd2, 5'd3, 5'd0, `FN_ADDU},
    {`OP_SPECIAL, 5'd3, 5'd1, 5'd4, 5'd0, `FN_SUBU},
    {`OP_SPECIAL, 5'd0, 5'd4, 5'd5, 5'd3, `FN_SLL},
    {`OP_SPECIAL, 5'd5, 5'd3, 5'd6, 5'd0, `FN_AND},
    {`OP_SPECIAL, 5'd1, 5'd5, 5'd7, 5'd0, `FN_SLT},
    {`OP_SPECIAL, 5'd6, 5'd7, 5'd8, 5'd0, `FN_OR},
    {`OP_SW, 5'd0, 5'd3, 16'h0010},
    {`OP_SW, 5'd0, 5'd4, 16'h0014},
    {`OP_SW, 5'd0, 5'd5, 16'h0018},
    {`OP_SW, 5'd0, 5'd6, 16'h001c},
    {`OP_SW, 5'd0, 5'd7, 16'h0020},
    {`OP_SW, 5'd0, 5'd8, 16'h0024},
    {`OP_J, 26'h0000c0f},
    // Load then dependent use at 16
    {`OP_ADDIU, 5'd0, 5'd3, 16'd100},
    {`OP_LW, 5'd0, 5'd1, 16'h0040},
    {`OP_SPECIAL, 5'd1, 5'd3, 5'd2, 5'd0, `FN_ADDU},
    {`OP_SW, 5'd0, 5'd2, 16'h0050},
    {`OP_LW, 5'd0, 5'd4, 16'h0044},
    {`OP_SW, 5'd0, 5'd4, 16'h0054},
    {`OP_J, 26'h0000c06},
    // Branches and a jump at 23 where skipped stores mark the wrong path
    {`OP_ADDIU, 5'd0, 5'd1, 16'd1},
    {`OP_ADDIU, 5'd0, 5'd2, 16'd1},
    {`OP_BEQ, 5'd1, 5'd2, 16'd2},
    {`OP_SW, 5'd0, 5'd1, 16'h0060},
    {`OP_SW, 5'd0, 5'd1, 16'h0064},
    {`OP_BNE, 5'd1, 5'd2, 16'd1},
    {`OP_SW, 5'd0, 5'd2, 16'h0068},
    {`OP_BEQ, 5'd1, 5'd0, 16'd1},
    {`OP_ADDIU, 5'd0, 5'd3, 16'd9},
    {`OP_BNE, 5'd3, 5'd0, 16'd1},
    {`OP_SW, 5'd0, 5'd3, 16'h006c},
    {`OP_SW, 5'd0, 5'd3, 16'h0070},
    {`OP_J, 26'h0000c0e},
    {`OP_SW, 5'd0, 5'd1, 16'h0074},
    {`OP_SW, 5'd0, 5'd2, 16'h0078},
    {`OP_J, 26'h0000c0f},
    // Writes to register 0 at 39
    {`OP_ADDIU, 5'd0, 5'd0, 16'd77},
    {`OP_SW, 5'd0, 5'd0, 16'h0080},
    {`OP_ORI, 5'd0, 5'd0, 16'd5},
    {`OP_SW, 5'd0, 5'd0, 16'h0084},
    {`OP_J, 26'h0000c04}
};

`endif

/* tests/cpuTb.sv */
`include "miniMips_settings.svh"

module cpuTb;
    logic          clk;
    logic          rstN;
    cpuPkg::word_t IAddr;
    cpuPkg::word_t IData;
    logic          IReady;
    cpuPkg::word_t DAddr;
    logic          DREn;
    logic          DWEn;
    cpuPkg::word_t DWData;
    cpuPkg::word_t DRData;
    logic          DReady;

    cpuPkg::word_t imem [64];
    cpuPkg::word_t dmem [256];
    cpuPkg::word_t expAddr [$];
    cpuPkg::word_t expData [$];
    integer        seed = 32'h8d13;
    string         testName = "none";
    int            readyMode = 0;
    int            storeIdx = 0;
    bit            running = 1'b0;
    int            errors = 0;
    int            testErrors = 0;
    int            testsRun = 0;
    int            testsFailed = 0;
    int            cycles = 0;
    int            cycleLimit = 200;

    `include "tbPrograms.svh"

    cpuCore cpuCore_i (
        .clk(clk), .rstN(rstN),
        .IAddr(IAddr), .IData(IData), .IReady(IReady),
        .DAddr(DAddr), .DREn(DREn), .DWEn(DWEn), .DWData(DWData),
        .DRData(DRData), .DReady(DReady)
    );

    assign IData = imem[IAddr[7:2]];
    assign DRData = dmem[DAddr[9:2]];

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ISA model without delay slot that returns the executed instruction count
    function automatic int runModel(input cpuPkg::word_t prog [64],
                                    input cpuPkg::word_t mem [256]);
        cpuPkg::word_t r [32];
        cpuPkg::word_t pc;
        cpuPkg::word_t nextPc;
        cpuPkg::word_t ins;
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t sx;
        cpuPkg::word_t addr;
        int            steps;
        expAddr.delete();
        expData.delete();
        for (int i = 0; i < 32; i++) r[i] = '0;
        pc = `RESET_PC;
        for (steps = 1; steps < 1000; steps++) begin
            ins = prog[(pc - `RESET_PC) >> 2];
            a = r[ins[25:21]];
            b = r[ins[20:16]];
            sx = {{16{ins[15]}}, ins[15:0]};
            addr = a + sx;
            nextPc = pc + 32'd4;
            case (ins[31:26])
                `OP_SPECIAL: case (ins[5:0])
                    `FN_ADDU: r[ins[15:11]] = a + b;
                    `FN_SUBU: r[ins[15:11]] = a - b;
                    `FN_AND:  r[ins[15:11]] = a & b;
                    `FN_OR:   r[ins[15:11]] = a | b;
                    `FN_SLT:  r[ins[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FN_SLL:  r[ins[15:11]] = b << ins[10:6];
                    default:  ;
                endcase
                `OP_ADDIU: r[ins[20:16]] = addr;
                `OP_ORI:   r[ins[20:16]] = a | {16'h0000, ins[15:0]};
                `OP_LUI:   r[ins[20:16]] = {ins[15:0], 16'h0000};
                `OP_LW:    r[ins[20:16]] = mem[addr[9:2]];
                `OP_SW: begin
                    mem[addr[9:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                end
                `OP_BEQ: if (a == b) nextPc = pc + 32'd4 + (sx << 2);
                `OP_BNE: if (a != b) nextPc = pc + 32'd4 + (sx << 2);
                `OP_J: begin
                    nextPc = {nextPc[31:28], ins[25:0], 2'b00};
                    if (nextPc == pc) return steps;
                end
                default: ;
            endcase
            r[0] = '0;
            pc = nextPc;
        end
        return steps;
    endfunction

    task automatic check(input string what, input cpuPkg::word_t expected,
                         input cpuPkg::word_t actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s: expected %h, actual %h", testName, what, expected, actual);
            errors++;
            testErrors++;
        end
    endtask

    always @(posedge clk) begin : readyDrive
        cpuPkg::word_t rnd;
        rnd = $random(seed);
        IReady <= (readyMode == 2) ? rnd[0] : (readyMode == 1);
        DReady <= (readyMode == 2) ? rnd[1] : (readyMode == 1);
    end

    // Store monitor and data memory write
    always @(posedge clk) begin
        if (!rstN) begin
            storeIdx <= 0;
        end else if (DWEn && DReady) begin
            dmem[DAddr[9:2]] = DWData;
            if (running && storeIdx < expAddr.size()) begin
                check("store address", expAddr[storeIdx], DAddr);
                check("store data", expData[storeIdx], DWData);
                storeIdx <= storeIdx + 1;
            end else if (running) begin
                $display("Unexpected extra store to %h in %s", DAddr, testName);
                errors++;
                testErrors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout: the program of %s did not finish", testName);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic applyReset();
        running = 1'b0;
        @(posedge clk);
        rstN <= 1'b0;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        running = 1'b1;
    endtask

    task automatic finishTest(input int stores);
        testsRun++;
        if (testErrors != 0) testsFailed++;
        $display("%s: %s, %0d stores, %0d errors", testName,
                 (testErrors == 0) ? "ok" : "FAILED", stores, testErrors);
        testErrors = 0;
    endtask

    task automatic runTest(input string name, input int prog, input int mode);
        int steps;
        @(negedge clk);
        running = 1'b0;
        testName = name;
        for (int i = 0; i < 64; i++) imem[i] = '0;
        for (int i = 0; i < progLen[prog]; i++) imem[i] = progWords[progStart[prog] + i];
        for (int i = 0; i < 256; i++) dmem[i] = $random(seed);
        steps = runModel(imem, dmem);
        cycleLimit += 20 * steps + 200;
        readyMode = mode;
        applyReset();
        while (storeIdx < expAddr.size()) @(posedge clk);
        // Extra cycles catch wrong-path stores
        repeat (20) @(posedge clk);
        finishTest(expAddr.size());
    endtask

    initial begin
        rstN <= 1'b0;
        IReady <= 1'b0;
        DReady <= 1'b0;
        for (int i = 0; i < 64; i++) imem[i] = '0;
        for (int i = 0; i < 256; i++) dmem[i] = '0;
        testName = "resetIdle";
        readyMode = 0;
        applyReset();
        repeat (8) begin
            @(negedge clk);
            check("DREn", 32'd0, {31'b0, DREn});
            check("DWEn", 32'd0, {31'b0, DWEn});
            check("IAddr", `RESET_PC, IAddr);
        end
        finishTest(0);
        runTest("aluChain", 0, 1);
        runTest("loadUse", 1, 1);
        runTest("branches", 2, 1);
        runTest("loadUseRandomReady", 1, 2);
        runTest("branchesRandomReady", 2, 2);
        runTest("zeroRegister", 3, 1);
        $display("Tests: %0d run, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* miniMips.f */
+incdir+common
+incdir+tests
common/cpuPkg.sv
decode/regFile.sv
decode/decodeStage.sv
hdl/executeStage.sv
hdl/resultStage.sv
hdl/cpuCore.sv
tests/cpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= cpuTb
FILELIST ?= miniMips.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run cpuTb and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Finished with no errors" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
